// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exu_alu_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
logic/alu_cfg_pkg.sv
logic/alu_op_pkg.sv
logic/exu_alu_rglr.sv
logic/exu_alu_bjp.sv
logic/exu_alu_dpath.sv
logic/exu_alu.sv
verif/exu_alu_sva.sv
verif/exu_alu_tb.sv

// ==== logic/alu_cfg_pkg.sv ====
// ALU config package: datapath width constants for the execute stage
package alu_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Data width
  ////////////////////////////////////////////////////////////

  // Integer register width
  localparam int unsigned xlen = 32;

  ////////////////////////////////////////////////////////////
  // Shared adder
  ////////////////////////////////////////////////////////////

  // One extra bit on top of xlen
  // It carries the sign of the difference for compares
  localparam int unsigned alu_adder_width = xlen + 1;

endpackage

// ==== logic/alu_op_pkg.sv ====
// ALU op package: operation codes for the regular ALU and the branch unit
package alu_op_pkg;

  ////////////////////////////////////////////////////////////
  // Regular ALU op codes
  ////////////////////////////////////////////////////////////

  localparam int unsigned alu_op_w = 4;

  localparam logic [alu_op_w-1:0] alu_op_add  = 4'd0;
  localparam logic [alu_op_w-1:0] alu_op_sub  = 4'd1;
  localparam logic [alu_op_w-1:0] alu_op_xor  = 4'd2;
  localparam logic [alu_op_w-1:0] alu_op_or   = 4'd3;
  localparam logic [alu_op_w-1:0] alu_op_and  = 4'd4;
  localparam logic [alu_op_w-1:0] alu_op_sll  = 4'd5;
  localparam logic [alu_op_w-1:0] alu_op_srl  = 4'd6;
  localparam logic [alu_op_w-1:0] alu_op_sra  = 4'd7;
  localparam logic [alu_op_w-1:0] alu_op_slt  = 4'd8;
  localparam logic [alu_op_w-1:0] alu_op_sltu = 4'd9;
  localparam logic [alu_op_w-1:0] alu_op_lui  = 4'd10;
  // Codes 11 to 15 are unused and give a zero result

  ////////////////////////////////////////////////////////////
  // Branch and jump op codes
  ////////////////////////////////////////////////////////////

  localparam int unsigned bjp_op_w = 3;

  localparam logic [bjp_op_w-1:0] bjp_op_beq  = 3'd0;
  localparam logic [bjp_op_w-1:0] bjp_op_bne  = 3'd1;
  localparam logic [bjp_op_w-1:0] bjp_op_blt  = 3'd2;
  localparam logic [bjp_op_w-1:0] bjp_op_bge  = 3'd3;
  localparam logic [bjp_op_w-1:0] bjp_op_bltu = 3'd4;
  localparam logic [bjp_op_w-1:0] bjp_op_bgeu = 3'd5;
  localparam logic [bjp_op_w-1:0] bjp_op_jal  = 3'd6;

  // Return address is pc plus one instruction
  localparam int unsigned jal_link_ofs = 4;

endpackage

// ==== logic/exu_alu.sv ====
// Integer execute stage: two requestors sharing one ALU datapath
`timescale 1ns/10ps

module exu_alu (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            disp_valid,
  input  logic                            disp_is_bjp,
  input  logic [alu_op_pkg::alu_op_w-1:0] disp_op,
  input  logic                            disp_use_imm,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_rs1,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_rs2,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_imm,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_pc,
  output logic                            wbck_valid,
  output logic [alu_cfg_pkg::xlen-1:0]    wbck_data,
  output logic                            bjp_valid,
  output logic                            bjp_taken,
  output logic [alu_cfg_pkg::xlen-1:0]    bjp_target,
  output logic [alu_cfg_pkg::xlen-1:0]    bjp_link
);
  import alu_cfg_pkg::*;

  // Regular ALU to datapath
  logic            alu_req;
  logic            alu_req_add, alu_req_sub, alu_req_xor, alu_req_or, alu_req_and;
  logic            alu_req_sll, alu_req_srl, alu_req_sra;
  logic            alu_req_slt, alu_req_sltu, alu_req_lui;
  logic [xlen-1:0] alu_req_op1;
  logic [xlen-1:0] alu_req_op2;

  // Branch unit to datapath
  logic            bjp_req;
  logic            bjp_req_cmp_eq, bjp_req_cmp_ne, bjp_req_cmp_lt, bjp_req_cmp_gt;
  logic            bjp_req_cmp_ltu, bjp_req_cmp_gtu, bjp_req_add;
  logic [xlen-1:0] bjp_req_op1;
  logic [xlen-1:0] bjp_req_op2;

  // Datapath back to both
  logic [xlen-1:0] dpath_res;
  logic            cmp_res;

  exu_alu_rglr u_rglr (
    .clk, .reset, .disp_valid, .disp_is_bjp, .disp_op, .disp_use_imm,
    .disp_rs1, .disp_rs2, .disp_imm, .dpath_res,
    .alu_req, .alu_req_add, .alu_req_sub, .alu_req_xor, .alu_req_or, .alu_req_and,
    .alu_req_sll, .alu_req_srl, .alu_req_sra, .alu_req_slt, .alu_req_sltu,
    .alu_req_lui, .alu_req_op1, .alu_req_op2,
    .wbck_valid, .wbck_data
  );

  exu_alu_bjp u_bjp (
    .clk, .reset, .disp_valid, .disp_is_bjp, .disp_op,
    .disp_rs1, .disp_rs2, .disp_imm, .disp_pc, .dpath_res, .cmp_res,
    .bjp_req, .bjp_req_cmp_eq, .bjp_req_cmp_ne, .bjp_req_cmp_lt, .bjp_req_cmp_gt,
    .bjp_req_cmp_ltu, .bjp_req_cmp_gtu, .bjp_req_add, .bjp_req_op1, .bjp_req_op2,
    .bjp_valid, .bjp_taken, .bjp_target, .bjp_link
  );

  exu_alu_dpath u_dpath (
    .alu_req, .alu_req_add, .alu_req_sub, .alu_req_xor, .alu_req_or, .alu_req_and,
    .alu_req_sll, .alu_req_srl, .alu_req_sra, .alu_req_slt, .alu_req_sltu,
    .alu_req_lui, .alu_req_op1, .alu_req_op2,
    .bjp_req, .bjp_req_cmp_eq, .bjp_req_cmp_ne, .bjp_req_cmp_lt, .bjp_req_cmp_gt,
    .bjp_req_cmp_ltu, .bjp_req_cmp_gtu, .bjp_req_add, .bjp_req_op1, .bjp_req_op2,
    .dpath_res, .cmp_res
  );

endmodule

// ==== logic/exu_alu_bjp.sv ====
// Branch/jump requestor: decodes the branch op, forms the target, registers the outcome
`timescale 1ns/10ps

module exu_alu_bjp (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            disp_valid,
  input  logic                            disp_is_bjp,
  input  logic [alu_op_pkg::alu_op_w-1:0] disp_op,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_rs1,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_rs2,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_imm,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_pc,
  input  logic [alu_cfg_pkg::xlen-1:0]    dpath_res,
  input  logic                            cmp_res,
  output logic                            bjp_req,
  output logic                            bjp_req_cmp_eq,
  output logic                            bjp_req_cmp_ne,
  output logic                            bjp_req_cmp_lt,
  output logic                            bjp_req_cmp_gt,
  output logic                            bjp_req_cmp_ltu,
  output logic                            bjp_req_cmp_gtu,
  output logic                            bjp_req_add,
  output logic [alu_cfg_pkg::xlen-1:0]    bjp_req_op1,
  output logic [alu_cfg_pkg::xlen-1:0]    bjp_req_op2,
  output logic                            bjp_valid,
  output logic                            bjp_taken,
  output logic [alu_cfg_pkg::xlen-1:0]    bjp_target,
  output logic [alu_cfg_pkg::xlen-1:0]    bjp_link
);
  import alu_cfg_pkg::*;
  import alu_op_pkg::*;

  logic [bjp_op_w-1:0] bjp_op;
  logic                is_jal;
  logic [xlen-1:0]     target_nxt;

  assign bjp_req = disp_valid & disp_is_bjp;

  // Branch codes live in the low bits of the shared op field
  assign bjp_op = disp_op[bjp_op_w-1:0];
  assign is_jal = (bjp_op == bjp_op_jal);

  // bge and bgeu use the greater-or-equal compares
  assign bjp_req_cmp_eq  = (bjp_op == bjp_op_beq);
  assign bjp_req_cmp_ne  = (bjp_op == bjp_op_bne);
  assign bjp_req_cmp_lt  = (bjp_op == bjp_op_blt);
  assign bjp_req_cmp_gt  = (bjp_op == bjp_op_bge);
  assign bjp_req_cmp_ltu = (bjp_op == bjp_op_bltu);
  assign bjp_req_cmp_gtu = (bjp_op == bjp_op_bgeu);
  assign bjp_req_add     = is_jal;

  // jal borrows the shared adder to form the link address
  assign bjp_req_op1 = is_jal ? disp_pc : disp_rs1;
  assign bjp_req_op2 = is_jal ? xlen'(jal_link_ofs) : disp_rs2;

  // Target has its own adder, the shared one is busy with the compare
  assign target_nxt = disp_pc + disp_imm;

  always_ff @(posedge clk) begin
    if (reset) begin
      bjp_valid  <= 1'b0;
      bjp_taken  <= 1'b0;
      bjp_target <= '0;
      bjp_link   <= '0;
    end else begin
      bjp_valid <= bjp_req;
      bjp_taken <= bjp_req & (is_jal | cmp_res);
      if (bjp_req) begin
        bjp_target <= target_nxt;
        bjp_link   <= is_jal ? dpath_res : '0;
      end
    end
  end

endmodule

// ==== logic/exu_alu_dpath.sv ====
// ALU datapath: shared adder, XOR-er, shifter and result mux for both requestors
`timescale 1ns/10ps

module exu_alu_dpath (
  // Regular ALU request
  input  logic                         alu_req,
  input  logic                         alu_req_add,
  input  logic                         alu_req_sub,
  input  logic                         alu_req_xor,
  input  logic                         alu_req_or,
  input  logic                         alu_req_and,
  input  logic                         alu_req_sll,
  input  logic                         alu_req_srl,
  input  logic                         alu_req_sra,
  input  logic                         alu_req_slt,
  input  logic                         alu_req_sltu,
  input  logic                         alu_req_lui,
  input  logic [alu_cfg_pkg::xlen-1:0] alu_req_op1,
  input  logic [alu_cfg_pkg::xlen-1:0] alu_req_op2,
  // Branch/jump request
  input  logic                         bjp_req,
  input  logic                         bjp_req_cmp_eq,
  input  logic                         bjp_req_cmp_ne,
  input  logic                         bjp_req_cmp_lt,
  input  logic                         bjp_req_cmp_gt,
  input  logic                         bjp_req_cmp_ltu,
  input  logic                         bjp_req_cmp_gtu,
  input  logic                         bjp_req_add,
  input  logic [alu_cfg_pkg::xlen-1:0] bjp_req_op1,
  input  logic [alu_cfg_pkg::xlen-1:0] bjp_req_op2,
  // Shared results
  output logic [alu_cfg_pkg::xlen-1:0] dpath_res,
  output logic                         cmp_res
);
  import alu_cfg_pkg::*;

  // Two operands followed by 17 op strobes
  logic [2*xlen+16:0]         alu_bundle;
  logic [2*xlen+16:0]         bjp_bundle;
  logic [xlen-1:0]            op1;
  logic [xlen-1:0]            op2;
  logic                       op_add, op_sub, op_xor, op_or, op_and;
  logic                       op_sll, op_srl, op_sra, op_slt, op_sltu, op_mvop2;
  logic                       op_cmp_eq, op_cmp_ne, op_cmp_lt, op_cmp_gt;
  logic                       op_cmp_ltu, op_cmp_gtu;
  logic                       op_shift, op_rshift, op_unsigned, op_slttu;
  logic [xlen-1:0]            shifter_in1;
  logic [4:0]                 shifter_in2;
  logic [xlen-1:0]            shifter_res;
  logic [xlen-1:0]            srl_res;
  logic [xlen-1:0]            sra_res;
  logic [xlen-1:0]            eff_mask;
  logic                       adder_sub, adder_on;
  logic [alu_adder_width-1:0] adder_op1;
  logic [alu_adder_width-1:0] adder_op2;
  logic [alu_adder_width-1:0] adder_res;
  logic                       xorer_on;
  logic [xlen-1:0]            xorer_res;
  logic                       op1_lt_op2, neq;

  // Reverse bit order so one left shifter covers right shifts too
  function automatic logic [31:0] bit_rev(input logic [31:0] val);
    logic [31:0] rev;
    for (int i = 0; i < 32; i++) begin
      rev[i] = val[31-i];
    end
    return rev;
  endfunction

  ////////////////////////////////////////////////////////////
  // Request mux
  ////////////////////////////////////////////////////////////

  assign alu_bundle = {alu_req_op1, alu_req_op2,
                       alu_req_add, alu_req_sub, alu_req_xor, alu_req_or, alu_req_and,
                       alu_req_sll, alu_req_srl, alu_req_sra, alu_req_slt, alu_req_sltu,
                       alu_req_lui, 6'b0};

  assign bjp_bundle = {bjp_req_op1, bjp_req_op2,
                       bjp_req_add, 10'b0,
                       bjp_req_cmp_eq, bjp_req_cmp_ne, bjp_req_cmp_lt, bjp_req_cmp_gt,
                       bjp_req_cmp_ltu, bjp_req_cmp_gtu};

  assign {op1, op2,
          op_add, op_sub, op_xor, op_or, op_and,
          op_sll, op_srl, op_sra, op_slt, op_sltu, op_mvop2,
          op_cmp_eq, op_cmp_ne, op_cmp_lt, op_cmp_gt, op_cmp_ltu, op_cmp_gtu} =
      ({$bits(alu_bundle){alu_req}} & alu_bundle)
    | ({$bits(bjp_bundle){bjp_req}} & bjp_bundle);

  ////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////

  assign op_rshift   = op_srl | op_sra;
  assign op_shift    = op_sll | op_rshift;
  assign shifter_in1 = {xlen{op_shift}} & (op_rshift ? bit_rev(op1) : op1);
  assign shifter_in2 = {5{op_shift}} & op2[4:0];
  assign shifter_res = shifter_in1 << shifter_in2;
  assign srl_res     = bit_rev(shifter_res);

  // Fill the vacated upper bits with the sign for sra
  assign eff_mask = {xlen{1'b1}} >> shifter_in2;
  assign sra_res  = (srl_res & eff_mask) | ({xlen{op1[xlen-1]}} & ~eff_mask);

  ////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////

  assign op_unsigned = op_sltu | op_cmp_ltu | op_cmp_gtu;
  assign adder_sub   = op_sub | op_slt | op_sltu
                     | op_cmp_lt | op_cmp_gt | op_cmp_ltu | op_cmp_gtu;
  assign adder_on    = op_add | adder_sub;

  assign adder_op1 = {xlen+1{adder_on}} & {~op_unsigned & op1[xlen-1], op1};
  assign adder_op2 = {xlen+1{adder_on}} & {~op_unsigned & op2[xlen-1], op2};

  // Subtract is op1 + ~op2 + 1
  assign adder_res = adder_op1 + (adder_sub ? ~adder_op2 : adder_op2)
                   + alu_adder_width'(adder_sub);

  // Sign of the widened difference
  assign op1_lt_op2 = adder_res[xlen];

  ////////////////////////////////////////////////////////////
  // XOR-er and compare
  ////////////////////////////////////////////////////////////

  assign xorer_on  = op_xor | op_cmp_eq | op_cmp_ne;
  assign xorer_res = ({xlen{xorer_on}} & op1) ^ ({xlen{xorer_on}} & op2);
  assign neq       = |xorer_res;

  assign cmp_res = (op_cmp_eq & ~neq)
                 | (op_cmp_ne & neq)
                 | ((op_cmp_lt | op_cmp_ltu) & op1_lt_op2)
                 | ((op_cmp_gt | op_cmp_gtu) & ~op1_lt_op2);

  // Result mux
  assign op_slttu = op_slt | op_sltu;

  assign dpath_res = ({xlen{op_add | op_sub}} & adder_res[xlen-1:0])
                   | ({xlen{op_xor}}          & xorer_res)
                   | ({xlen{op_or}}           & (op1 | op2))
                   | ({xlen{op_and}}          & (op1 & op2))
                   | ({xlen{op_sll}}          & shifter_res)
                   | ({xlen{op_srl}}          & srl_res)
                   | ({xlen{op_sra}}          & sra_res)
                   | ({xlen{op_mvop2}}        & op2)
                   | {{xlen-1{1'b0}}, op_slttu & op1_lt_op2};

endmodule

// ==== logic/exu_alu_rglr.sv ====
// Regular ALU requestor: decodes the op, picks op2 and registers the writeback
`timescale 1ns/10ps

module exu_alu_rglr (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            disp_valid,
  input  logic                            disp_is_bjp,
  input  logic [alu_op_pkg::alu_op_w-1:0] disp_op,
  input  logic                            disp_use_imm,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_rs1,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_rs2,
  input  logic [alu_cfg_pkg::xlen-1:0]    disp_imm,
  input  logic [alu_cfg_pkg::xlen-1:0]    dpath_res,
  output logic                            alu_req,
  output logic                            alu_req_add,
  output logic                            alu_req_sub,
  output logic                            alu_req_xor,
  output logic                            alu_req_or,
  output logic                            alu_req_and,
  output logic                            alu_req_sll,
  output logic                            alu_req_srl,
  output logic                            alu_req_sra,
  output logic                            alu_req_slt,
  output logic                            alu_req_sltu,
  output logic                            alu_req_lui,
  output logic [alu_cfg_pkg::xlen-1:0]    alu_req_op1,
  output logic [alu_cfg_pkg::xlen-1:0]    alu_req_op2,
  output logic                            wbck_valid,
  output logic [alu_cfg_pkg::xlen-1:0]    wbck_data
);
  import alu_op_pkg::*;

  // Everything not flagged as branch/jump belongs here
  assign alu_req = disp_valid & ~disp_is_bjp;

  // One-hot op strobes, unused codes raise none
  assign alu_req_add  = (disp_op == alu_op_add);
  assign alu_req_sub  = (disp_op == alu_op_sub);
  assign alu_req_xor  = (disp_op == alu_op_xor);
  assign alu_req_or   = (disp_op == alu_op_or);
  assign alu_req_and  = (disp_op == alu_op_and);
  assign alu_req_sll  = (disp_op == alu_op_sll);
  assign alu_req_srl  = (disp_op == alu_op_srl);
  assign alu_req_sra  = (disp_op == alu_op_sra);
  assign alu_req_slt  = (disp_op == alu_op_slt);
  assign alu_req_sltu = (disp_op == alu_op_sltu);
  assign alu_req_lui  = (disp_op == alu_op_lui);

  assign alu_req_op1 = disp_rs1;
  assign alu_req_op2 = disp_use_imm ? disp_imm : disp_rs2;

  // Writeback stage, one cycle after dispatch
  always_ff @(posedge clk) begin
    if (reset) begin
      wbck_valid <= 1'b0;
      wbck_data  <= '0;
    end else begin
      wbck_valid <= alu_req;
      if (alu_req) begin
        wbck_data <= dpath_res;
      end
    end
  end

endmodule

// ==== verif/exu_alu_sva.sv ====
// Execute stage assertions: output valids checked against dispatch and reset
`timescale 1ns/10ps

module exu_alu_sva (
  input logic clk,
  input logic reset,
  input logic disp_valid,
  input logic disp_is_bjp,
  input logic wbck_valid,
  input logic bjp_valid
);

  // Only one requestor owns an instruction
  a_one_valid: assert property (@(posedge clk) !(wbck_valid && bjp_valid))
    else $error("wbck_valid and bjp_valid high in the same cycle");

  a_wbck_cause: assert property (@(posedge clk) disable iff (reset)
    wbck_valid |-> $past(disp_valid && !disp_is_bjp))
    else $error("wbck_valid without a regular dispatch one cycle earlier");

  a_bjp_cause: assert property (@(posedge clk) disable iff (reset)
    bjp_valid |-> $past(disp_valid && disp_is_bjp))
    else $error("bjp_valid without a branch dispatch one cycle earlier");

  // Every dispatch produces its output on the next cycle
  a_wbck_next: assert property (@(posedge clk) disable iff (reset)
    disp_valid && !disp_is_bjp |=> wbck_valid)
    else $error("regular dispatch not followed by wbck_valid");

  a_bjp_next: assert property (@(posedge clk) disable iff (reset)
    disp_valid && disp_is_bjp |=> bjp_valid)
    else $error("branch dispatch not followed by bjp_valid");

  a_reset_quiet: assert property (@(posedge clk)
    reset && $past(reset) |-> !wbck_valid && !bjp_valid)
    else $error("output valid high during reset");

endmodule

// ==== verif/exu_alu_tb.sv ====
// Execute stage testbench: random and corner instructions checked against a reference model
`timescale 1ns/10ps

module exu_alu_tb;
  import alu_cfg_pkg::*;
  import alu_op_pkg::*;

  localparam int clk_period = 4;
  localparam int n_rand     = 400;
  localparam int n_dir      = 5 * 5 * 16 * 2;
  localparam int n_instr    = n_rand + n_dir;
  localparam logic [xlen-1:0] corners [5] = '{32'h0, 32'hffffffff, 32'h80000000,
                                              32'd31, 32'h7fffffff};

  typedef struct packed {
    logic            wv;
    logic [xlen-1:0] wd;
    logic            bv;
    logic            bt;
    logic [xlen-1:0] tgt;
    logic [xlen-1:0] lnk;
  } exp_t;

  logic                clk = 1'b0;
  logic                reset;
  logic                disp_valid, disp_is_bjp, disp_use_imm;
  logic [alu_op_w-1:0] disp_op;
  logic [xlen-1:0]     disp_rs1, disp_rs2, disp_imm, disp_pc;
  logic                wbck_valid, bjp_valid, bjp_taken;
  logic [xlen-1:0]     wbck_data, bjp_target, bjp_link;

  exp_t            exp_q[$];
  exp_t            cur;
  logic [xlen-1:0] rnd_state = 32'hbf31569e;
  int              err_cnt   = 0;
  int              n_cmp     = 0;

  exu_alu u_exu_alu (.*);

  bind exu_alu exu_alu_sva u_sva (.*);

  always #(clk_period / 2) clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [xlen-1:0] next_rand();
    rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
    return rnd_state;
  endfunction

  // Roughly half the picks land on a corner value
  function automatic logic [xlen-1:0] pick_operand(input logic [xlen-1:0] r);
    case (r[31:29])
      3'd0:    return 32'h0;
      3'd1:    return 32'hffffffff;
      3'd2:    return 32'h80000000;
      3'd3:    return 32'd31;
      default: return r;
    endcase
  endfunction

  // Expected outputs one cycle after a dispatch
  function automatic exp_t ref_model(input logic v, input logic is_bjp,
      input logic [alu_op_w-1:0] op, input logic use_imm,
      input logic [xlen-1:0] rs1, rs2, imm, pc);
    exp_t            e;
    logic [xlen-1:0] op2;
    logic [4:0]      sh;
    e    = '0;
    op2  = use_imm ? imm : rs2;
    sh   = op2[4:0];
    e.wv = v & ~is_bjp;
    e.bv = v & is_bjp;
    if (e.wv) begin
      case (op)
        alu_op_add:  e.wd = rs1 + op2;
        alu_op_sub:  e.wd = rs1 - op2;
        alu_op_xor:  e.wd = rs1 ^ op2;
        alu_op_or:   e.wd = rs1 | op2;
        alu_op_and:  e.wd = rs1 & op2;
        alu_op_sll:  e.wd = rs1 << sh;
        alu_op_srl:  e.wd = rs1 >> sh;
        alu_op_sra:  e.wd = $signed(rs1) >>> sh;
        alu_op_slt:  e.wd = {31'b0, $signed(rs1) < $signed(op2)};
        alu_op_sltu: e.wd = {31'b0, rs1 < op2};
        alu_op_lui:  e.wd = op2;
        default:     e.wd = '0;
      endcase
    end
    if (e.bv) begin
      e.tgt = pc + imm;
      case (op[bjp_op_w-1:0])
        bjp_op_beq:  e.bt = (rs1 == rs2);
        bjp_op_bne:  e.bt = (rs1 != rs2);
        bjp_op_blt:  e.bt = ($signed(rs1) < $signed(rs2));
        bjp_op_bge:  e.bt = ($signed(rs1) >= $signed(rs2));
        bjp_op_bltu: e.bt = (rs1 < rs2);
        bjp_op_bgeu: e.bt = (rs1 >= rs2);
        bjp_op_jal: begin
          e.bt  = 1'b1;
          e.lnk = pc + 32'd4;
        end
        default:     e.bt = 1'b0;
      endcase
    end
    return e;
  endfunction

  task automatic check_val(input string name, input logic [xlen-1:0] exp_v,
      input logic [xlen-1:0] act_v);
    if (exp_v !== act_v) begin
      err_cnt++;
      $display("ERROR %s expected %h actual %h", name, exp_v, act_v);
      $display("ERRORS FOUND");
      $fatal(1, "output mismatch");
    end
  endtask

  task automatic dispatch(input logic v, input logic is_bjp, input logic [alu_op_w-1:0] op,
      input logic use_imm, input logic [xlen-1:0] rs1, rs2, imm, pc);
    @(negedge clk);
    disp_valid   = v;
    disp_is_bjp  = is_bjp;
    disp_op      = op;
    disp_use_imm = use_imm;
    disp_rs1     = rs1;
    disp_rs2     = rs2;
    disp_imm     = imm;
    disp_pc      = pc;
    exp_q.push_back(ref_model(v, is_bjp, op, use_imm, rs1, rs2, imm, pc));
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [xlen-1:0] r1, r2, im, pc, ctl;
    reset        = 1'b1;
    disp_valid   = 1'b1;
    disp_is_bjp  = 1'b0;
    disp_op      = '0;
    disp_use_imm = 1'b0;
    disp_rs1     = '0;
    disp_rs2     = '0;
    disp_imm     = '0;
    disp_pc      = '0;
    // Dispatches to both requestors while reset holds the valids low
    repeat (16) begin
      @(negedge clk);
      disp_is_bjp = ~disp_is_bjp;
    end
    reset      = 1'b0;
    disp_valid = 1'b0;
    check_val("reset wbck_valid", '0, xlen'(wbck_valid));
    check_val("reset bjp_valid", '0, xlen'(bjp_valid));

    // Every op code on every corner pair, equal pairs included
    for (int a = 0; a < 5; a++) begin
      for (int b = 0; b < 5; b++) begin
        for (int k = 0; k < 16; k++) begin
          for (int j = 0; j < 2; j++) begin
            pc = next_rand();
            dispatch(1'b1, j[0], k[3:0], 1'b0, corners[a], corners[b], corners[b], pc);
          end
        end
      end
    end

    for (int i = 0; i < n_rand; i++) begin
      r1  = pick_operand(next_rand());
      r2  = next_rand();
      r2  = r2[28] ? r1 : pick_operand(r2);
      im  = pick_operand(next_rand());
      pc  = next_rand();
      ctl = next_rand();
      dispatch(ctl[31:29] != 3'd0, ctl[28], ctl[27:24], ctl[23], r1, r2, im, pc);
    end

    dispatch(1'b0, 1'b0, '0, 1'b0, '0, '0, '0, '0);
    dispatch(1'b0, 1'b1, '0, 1'b0, '0, '0, '0, '0);
    while (exp_q.size() != 0) @(negedge clk);
    @(negedge clk);
    if (err_cnt == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // Compare a little after the capturing edge
  always @(posedge clk) begin
    #1;
    if (exp_q.size() > 0) begin
      cur = exp_q.pop_front();
      n_cmp++;
      check_val($sformatf("cycle %0d wbck_valid", n_cmp), xlen'(cur.wv), xlen'(wbck_valid));
      check_val($sformatf("cycle %0d bjp_valid", n_cmp), xlen'(cur.bv), xlen'(bjp_valid));
      check_val($sformatf("cycle %0d bjp_taken", n_cmp), xlen'(cur.bt), xlen'(bjp_taken));
      if (cur.wv) begin
        check_val($sformatf("cycle %0d wbck_data", n_cmp), cur.wd, wbck_data);
      end
      if (cur.bv) begin
        check_val($sformatf("cycle %0d bjp_target", n_cmp), cur.tgt, bjp_target);
        check_val($sformatf("cycle %0d bjp_link", n_cmp), cur.lnk, bjp_link);
      end
    end
  end

  initial begin
    #(20 * n_instr * clk_period);
    $display("Timeout: the run did not complete within %0d ns", 20 * n_instr * clk_period);
    $display("ERRORS FOUND");
    $fatal(1, "watchdog expired");
  end

endmodule
